// File: hdl/pueo_command_decoder.sv
`timescale 1ns/10ps
module pueo_command_decoder (
    input  logic                                    sysclk_i,
    input  logic                                    rst_n_i,
    input  logic [turfio_pkg::WB_DATA_WIDTH-1:0]    command_i,
    input  logic                                    command_valid_i,
    output logic                                    cmd_sync_o,
    output logic                                    cmd_pps_o,
    output logic [turfio_pkg::TRIG_TIME_WIDTH-1:0]  trig_time_o,
    output logic                                    trig_valid_o
);

    // Opcode out of the top nibble
    turfio_pkg::cmd_op_e op;
    logic                is_sync;
    logic                is_pps;
    logic                is_trig;

    assign op = turfio_pkg::cmd_op_e'(command_i[31:28]);

    always_comb begin
        is_sync = 1'b0;
        is_pps  = 1'b0;
        is_trig = 1'b0;
        case (op)
            turfio_pkg::CMD_SYNC: is_sync = 1'b1;
            turfio_pkg::CMD_PPS:  is_pps  = 1'b1;
            turfio_pkg::CMD_TRIG: is_trig = 1'b1;
            // NOP and unknown codes
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // One-cycle strobes
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd_sync_o   <= 1'b0;
            cmd_pps_o    <= 1'b0;
            trig_valid_o <= 1'b0;
        end else begin
            cmd_sync_o   <= command_valid_i & is_sync;
            cmd_pps_o    <= command_valid_i & is_pps;
            trig_valid_o <= command_valid_i & is_trig;
        end
    end

    // Trigger time holds until the next trigger
    always_ff @(posedge sysclk_i) begin
        if (command_valid_i && is_trig) begin
            trig_time_o <= command_i[turfio_pkg::TRIG_TIME_WIDTH-1:0];
        end
    end

endmodule

// File: hdl/pueo_turfio.sv
`timescale 1ns/10ps
module pueo_turfio #(
    parameter logic [31:0] IDENT         = 32'h5446494F,
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd0,
    parameter logic [7:0]  VER_REV       = 8'd21,
    parameter logic [15:0] FIRMWARE_DATE = 16'd0
) (
    input  logic                                      sysclk_i,
    input  logic                                      rst_n_i,
    // Register bus from the outside master
    input  logic                                      wb_cyc_i,
    input  logic                                      wb_stb_i,
    input  logic                                      wb_we_i,
    input  logic [turfio_pkg::WB_ADDR_WIDTH-1:0]      wb_adr_i,
    input  logic [turfio_pkg::WB_DATA_WIDTH-1:0]      wb_dat_i,
    output logic [turfio_pkg::WB_DATA_WIDTH-1:0]      wb_dat_o,
    output logic                                      wb_ack_o,
    output logic                                      wb_err_o,
    // Decoded command outputs
    output logic                                      cmd_pps_o,
    output logic [turfio_pkg::TRIG_TIME_WIDTH-1:0]    trig_time_o,
    output logic                                      trig_valid_o,
    // Sync period and clock time
    output logic                                      sync_o,
    output logic [turfio_pkg::CLOCK_COUNT_WIDTH-1:0]  sysclk_count_o
);

    ////////////////////////////////////////////////////////////
    // Slave bus wires
    ////////////////////////////////////////////////////////////
    logic                                  id_stb;
    logic                                  cmd_stb;
    logic                                  slv_we;
    logic [turfio_pkg::SLV_ADDR_WIDTH-1:0] slv_adr;
    logic [turfio_pkg::WB_DATA_WIDTH-1:0]  slv_dat;
    logic [turfio_pkg::WB_DATA_WIDTH-1:0]  id_dat;
    logic [turfio_pkg::WB_DATA_WIDTH-1:0]  cmd_dat;
    logic                                  id_ack;
    logic                                  cmd_ack;

    // Command path
    logic [turfio_pkg::WB_DATA_WIDTH-1:0]  turf_command;
    logic                                  turf_command_valid;
    logic                                  turf_cmdsync;

    // Sync control levels
    logic                                  en_ext_sync;
    logic [7:0]                            sync_offset;
    logic [7:0]                            clock_offset;

    turfio_intercon u_intercon (
        .sysclk_i  (sysclk_i),
        .rst_n_i   (rst_n_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o),
        .wb_err_o  (wb_err_o),
        .id_stb_o  (id_stb),
        .cmd_stb_o (cmd_stb),
        .slv_we_o  (slv_we),
        .slv_adr_o (slv_adr),
        .slv_dat_o (slv_dat),
        .id_dat_i  (id_dat),
        .cmd_dat_i (cmd_dat),
        .id_ack_i  (id_ack),
        .cmd_ack_i (cmd_ack)
    );

    // Identification and sync control, region 0
    tio_id_ctrl #(
        .IDENT         (IDENT),
        .VER_MAJOR     (VER_MAJOR),
        .VER_MINOR     (VER_MINOR),
        .VER_REV       (VER_REV),
        .FIRMWARE_DATE (FIRMWARE_DATE)
    ) u_id_ctrl (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .stb_i          (id_stb),
        .we_i           (slv_we),
        .adr_i          (slv_adr),
        .dat_i          (slv_dat),
        .dat_o          (id_dat),
        .ack_o          (id_ack),
        .en_ext_sync_o  (en_ext_sync),
        .sync_offset_o  (sync_offset),
        .clock_offset_o (clock_offset)
    );

    // Command register, region 1
    turf_cmd_regs u_cmd_regs (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .stb_i           (cmd_stb),
        .we_i            (slv_we),
        .adr_i           (slv_adr),
        .dat_i           (slv_dat),
        .dat_o           (cmd_dat),
        .ack_o           (cmd_ack),
        .command_o       (turf_command),
        .command_valid_o (turf_command_valid)
    );

    pueo_command_decoder u_decoder (
        .sysclk_i        (sysclk_i),
        .rst_n_i         (rst_n_i),
        .command_i       (turf_command),
        .command_valid_i (turf_command_valid),
        .cmd_sync_o      (turf_cmdsync),
        .cmd_pps_o       (cmd_pps_o),
        .trig_time_o     (trig_time_o),
        .trig_valid_o    (trig_valid_o)
    );

    turfio_sync_sysclk_count u_synccount (
        .sysclk_i       (sysclk_i),
        .rst_n_i        (rst_n_i),
        .sync_req_i     (turf_cmdsync),
        .en_ext_sync_i  (en_ext_sync),
        .sync_offset_i  (sync_offset),
        .clock_offset_i (clock_offset),
        .sync_o         (sync_o),
        .sysclk_count_o (sysclk_count_o)
    );

endmodule

// File: hdl/tio_id_ctrl.sv
`timescale 1ns/10ps
module tio_id_ctrl #(
    parameter logic [31:0] IDENT         = 32'h5446494F,
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd0,
    parameter logic [7:0]  VER_REV       = 8'd21,
    parameter logic [15:0] FIRMWARE_DATE = 16'd0
) (
    input  logic                                   sysclk_i,
    input  logic                                   rst_n_i,
    input  logic                                   stb_i,
    input  logic                                   we_i,
    input  logic [turfio_pkg::SLV_ADDR_WIDTH-1:0]  adr_i,
    input  logic [turfio_pkg::WB_DATA_WIDTH-1:0]   dat_i,
    output logic [turfio_pkg::WB_DATA_WIDTH-1:0]   dat_o,
    output logic                                   ack_o,
    // Sync control levels
    output logic                                   en_ext_sync_o,
    output logic [7:0]                             sync_offset_o,
    output logic [7:0]                             clock_offset_o
);

    // Date up top, then major/minor/revision
    localparam logic [31:0] DATEVERSION = {FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    // First cycle of an access only
    logic                                  access;
    logic [turfio_pkg::WB_DATA_WIDTH-1:0]  rd_data;

    assign access = stb_i & ~ack_o;

    // Read mux, unknown offsets give zero
    always_comb begin
        case (adr_i)
            turfio_pkg::ID_REG_IDENT:   rd_data = IDENT;
            turfio_pkg::ID_REG_VERSION: rd_data = DATEVERSION;
            // Unused control bits read back as zero
            turfio_pkg::ID_REG_CTRL:
                rd_data = {8'h00, clock_offset_o, sync_offset_o, 7'h00, en_ext_sync_o};
            default:                    rd_data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Ack and control register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o          <= 1'b0;
            en_ext_sync_o  <= 1'b0;
            sync_offset_o  <= 8'h00;
            clock_offset_o <= 8'h00;
        end else begin
            ack_o <= access;
            // Control is the only writable offset
            if (access && we_i && adr_i == turfio_pkg::ID_REG_CTRL) begin
                en_ext_sync_o  <= dat_i[0];
                sync_offset_o  <= dat_i[15:8];
                clock_offset_o <= dat_i[23:16];
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge sysclk_i) begin
        if (access) begin
            dat_o <= rd_data;
        end
    end

endmodule

// File: hdl/turf_cmd_regs.sv
`timescale 1ns/10ps
module turf_cmd_regs (
    input  logic                                   sysclk_i,
    input  logic                                   rst_n_i,
    input  logic                                   stb_i,
    input  logic                                   we_i,
    input  logic [turfio_pkg::SLV_ADDR_WIDTH-1:0]  adr_i,
    input  logic [turfio_pkg::WB_DATA_WIDTH-1:0]   dat_i,
    output logic [turfio_pkg::WB_DATA_WIDTH-1:0]   dat_o,
    output logic                                   ack_o,
    // Command word toward the decoder
    output logic [turfio_pkg::WB_DATA_WIDTH-1:0]   command_o,
    output logic                                   command_valid_o
);

    logic access;
    logic cmd_hit;

    assign access  = stb_i & ~ack_o;
    assign cmd_hit = (adr_i == turfio_pkg::CMD_REG_COMMAND);

    // Address held by the master through the ack cycle
    assign dat_o = cmd_hit ? command_o : '0;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o           <= 1'b0;
            command_valid_o <= 1'b0;
            command_o       <= '0;
        end else begin
            ack_o <= access;
            // Strobe lines up with the write ack
            command_valid_o <= access & we_i & cmd_hit;
            if (access && we_i && cmd_hit) begin
                command_o <= dat_i;
            end
        end
    end

endmodule

// File: hdl/turfio_intercon.sv
`timescale 1ns/10ps
module turfio_intercon (
    input  logic                                   sysclk_i,
    input  logic                                   rst_n_i,
    // Outside bus master
    input  logic                                   wb_cyc_i,
    input  logic                                   wb_stb_i,
    input  logic                                   wb_we_i,
    input  logic [turfio_pkg::WB_ADDR_WIDTH-1:0]   wb_adr_i,
    input  logic [turfio_pkg::WB_DATA_WIDTH-1:0]   wb_dat_i,
    output logic [turfio_pkg::WB_DATA_WIDTH-1:0]   wb_dat_o,
    output logic                                   wb_ack_o,
    output logic                                   wb_err_o,
    // Slave side, shared we/adr/dat
    output logic                                   id_stb_o,
    output logic                                   cmd_stb_o,
    output logic                                   slv_we_o,
    output logic [turfio_pkg::SLV_ADDR_WIDTH-1:0]  slv_adr_o,
    output logic [turfio_pkg::WB_DATA_WIDTH-1:0]   slv_dat_o,
    input  logic [turfio_pkg::WB_DATA_WIDTH-1:0]   id_dat_i,
    input  logic [turfio_pkg::WB_DATA_WIDTH-1:0]   cmd_dat_i,
    input  logic                                   id_ack_i,
    input  logic                                   cmd_ack_i
);

    // Live request from the master
    logic                  req;
    // Decoded region, held stable by the master until ack/err
    turfio_pkg::region_e   region;
    logic                  unmapped;

    assign req    = wb_cyc_i & wb_stb_i;
    assign region = turfio_pkg::region_e'(wb_adr_i[turfio_pkg::WB_ADDR_WIDTH-1 -: 2]);

    always_comb begin
        unmapped = 1'b0;
        case (region)
            turfio_pkg::REGION_ID:  unmapped = 1'b0;
            turfio_pkg::REGION_CMD: unmapped = 1'b0;
            default:                unmapped = 1'b1;
        endcase
    end

    // One slave strobe at most
    assign id_stb_o  = req & (region == turfio_pkg::REGION_ID);
    assign cmd_stb_o = req & (region == turfio_pkg::REGION_CMD);
    // Slave sees the low address bits only
    assign slv_we_o  = wb_we_i;
    assign slv_adr_o = wb_adr_i[turfio_pkg::SLV_ADDR_WIDTH-1:0];
    assign slv_dat_o = wb_dat_i;

    // Return path from the selected slave
    always_comb begin
        wb_ack_o = 1'b0;
        wb_dat_o = '0;
        case (region)
            turfio_pkg::REGION_ID: begin
                wb_ack_o = id_ack_i;
                wb_dat_o = id_dat_i;
            end
            turfio_pkg::REGION_CMD: begin
                wb_ack_o = cmd_ack_i;
                wb_dat_o = cmd_dat_i;
            end
            // Unmapped, data stays zero
            default: begin
                wb_ack_o = 1'b0;
                wb_dat_o = '0;
            end
        endcase
    end

    // Error for unmapped regions
    // one cycle after the request, single pulse
    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_err_o <= 1'b0;
        end else begin
            wb_err_o <= req & unmapped & ~wb_err_o;
        end
    end

endmodule

// File: hdl/turfio_pkg.sv
package turfio_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    // Byte address seen by the outside master
    localparam int WB_ADDR_WIDTH  = 14;
    localparam int WB_DATA_WIDTH  = 32;
    // Address space of one slave, 4 kB
    localparam int SLV_ADDR_WIDTH = 12;

    // Region select sits in address bits 13:12
    // Regions 2 and 3 have no slave behind them
    typedef enum logic [1:0] {
        REGION_ID  = 2'd0,
        REGION_CMD = 2'd1
    } region_e;

    ////////////////////////////////////////////////////////////
    // Register offsets
    ////////////////////////////////////////////////////////////

    // Identification region
    localparam logic [SLV_ADDR_WIDTH-1:0] ID_REG_IDENT    = 12'h000;
    localparam logic [SLV_ADDR_WIDTH-1:0] ID_REG_VERSION  = 12'h004;
    localparam logic [SLV_ADDR_WIDTH-1:0] ID_REG_CTRL     = 12'h008;
    // Command region
    localparam logic [SLV_ADDR_WIDTH-1:0] CMD_REG_COMMAND = 12'h000;

    ////////////////////////////////////////////////////////////
    // TURF commands
    ////////////////////////////////////////////////////////////

    // Opcode in command bits 31:28, unlisted codes act as NOP
    typedef enum logic [3:0] {
        CMD_NOP  = 4'd0,
        CMD_SYNC = 4'd1,
        CMD_PPS  = 4'd2,
        CMD_TRIG = 4'd3
    } cmd_op_e;

    // Trigger time is command bits 14:0
    localparam int TRIG_TIME_WIDTH = 15;

    // 16-cycle sync period
    localparam int SYNC_PERIOD_BITS  = 4;
    localparam int CLOCK_COUNT_WIDTH = 48;

endpackage

// File: hdl/turfio_sync_sysclk_count.sv
`timescale 1ns/10ps
module turfio_sync_sysclk_count (
    input  logic                                      sysclk_i,
    input  logic                                      rst_n_i,
    input  logic                                      sync_req_i,
    input  logic                                      en_ext_sync_i,
    input  logic [7:0]                                sync_offset_i,
    input  logic [7:0]                                clock_offset_i,
    output logic                                      sync_o,
    output logic [turfio_pkg::CLOCK_COUNT_WIDTH-1:0]  sysclk_count_o
);

    // Position inside the sync period
    logic [turfio_pkg::SYNC_PERIOD_BITS-1:0] phase;
    // Request only counts with external sync on
    logic                                    sync_accept;

    assign sync_accept = sync_req_i & en_ext_sync_i;

    // Sync marks the first cycle of the period
    assign sync_o = (phase == '0);

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase          <= '0;
            sysclk_count_o <= '0;
        end else if (sync_accept) begin
            // Realign phase and clock time
            phase          <= sync_offset_i[turfio_pkg::SYNC_PERIOD_BITS-1:0];
            sysclk_count_o <= {{(turfio_pkg::CLOCK_COUNT_WIDTH-8){1'b0}}, clock_offset_i};
        end else begin
            // Phase wraps on its own width
            phase          <= phase + 1'b1;
            sysclk_count_o <= sysclk_count_o + 1'b1;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the register-bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module pueo_turfio_tb -f src.f \
    -Mdir obj_dir -o vsim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/vsim > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test completed successfully" sim.log \
    || { echo "Simulation stopped before the end"; exit 1; }
echo "Simulation PASSED"

// File: src.f
hdl/turfio_pkg.sv
hdl/turfio_intercon.sv
hdl/tio_id_ctrl.sv
hdl/turf_cmd_regs.sv
hdl/pueo_command_decoder.sv
hdl/turfio_sync_sysclk_count.sv
hdl/pueo_turfio.sv
testbench/pueo_turfio_checker.sv
testbench/pueo_turfio_tb.sv

// File: testbench/pueo_turfio_checker.sv
`timescale 1ns/10ps
module pueo_turfio_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic stb_i,
    input logic ack_i,
    input logic err_i,
    input logic pulse_i
);

    ////////////////////////////////////////////////////////////
    // Bus rules
    ////////////////////////////////////////////////////////////

    // Ack and err exclusive
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(ack_i && err_i))
        else $error("ack and err were high in the same cycle");

    // Ack only answers a request from the previous cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i) ack_i |-> $past(stb_i))
        else $error("ack rose without a preceding stb");

    // Same for err
    assert property (@(posedge clk_i) disable iff (!rst_n_i) err_i |-> $past(stb_i))
        else $error("err rose without a preceding stb");

    ////////////////////////////////////////////////////////////
    // Strobe rules
    ////////////////////////////////////////////////////////////

    // Strobes and bus responses last one cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i) pulse_i |=> !pulse_i)
        else $error("strobe stayed high for more than one cycle");

endmodule

// Outside bus side of the interconnect
bind turfio_intercon pueo_turfio_checker i_bus_checker (
    .clk_i   (sysclk_i),
    .rst_n_i (rst_n_i),
    .stb_i   (wb_cyc_i & wb_stb_i),
    .ack_i   (wb_ack_o),
    .err_i   (wb_err_o),
    .pulse_i (wb_ack_o | wb_err_o)
);

// Command slave, never raises err
bind turf_cmd_regs pueo_turfio_checker i_cmd_checker (
    .clk_i   (sysclk_i),
    .rst_n_i (rst_n_i),
    .stb_i   (stb_i),
    .ack_i   (ack_o),
    .err_i   (1'b0),
    .pulse_i (command_valid_o)
);

// File: testbench/pueo_turfio_tb.sv
`timescale 1ns/10ps
module pueo_turfio_tb;

    // Build values other than the defaults
    localparam logic [31:0] IDENT         = 32'h7f3a_19c6;
    localparam logic [3:0]  VER_MAJOR     = 4'd1;
    localparam logic [3:0]  VER_MINOR     = 4'd2;
    localparam logic [7:0]  VER_REV       = 8'd37;
    localparam logic [15:0] FIRMWARE_DATE = 16'h0a5c;
    localparam logic [31:0] CTRL_MASK     = 32'h00FF_FF01;
    localparam int          BUS_LIMIT     = 8;

    // Byte addresses, region in bits 13:12
    localparam logic [13:0] ADR_IDENT   = {turfio_pkg::REGION_ID, turfio_pkg::ID_REG_IDENT};
    localparam logic [13:0] ADR_VERSION = {turfio_pkg::REGION_ID, turfio_pkg::ID_REG_VERSION};
    localparam logic [13:0] ADR_CTRL    = {turfio_pkg::REGION_ID, turfio_pkg::ID_REG_CTRL};
    localparam logic [13:0] ADR_CMD     = {turfio_pkg::REGION_CMD, turfio_pkg::CMD_REG_COMMAND};

    typedef enum {STEP_READ, STEP_WRITE, STEP_ERR, STEP_CMD, STEP_SYNC} step_kind_e;

    // CMD steps pack the expected op in 31:28 and trigger time in 14:0
    // SYNC steps carry the control word written before them
    typedef struct {
        string       name;
        step_kind_e  kind;
        logic [13:0] adr;
        logic [31:0] wdata;
        logic [31:0] expected;
    } step_t;

    step_t steps[$];

    logic                                             sysclk = 1'b0;
    logic                                             rst_n;
    logic                                             wb_cyc;
    logic                                             wb_stb;
    logic                                             wb_we;
    logic [turfio_pkg::WB_ADDR_WIDTH-1:0]             wb_adr;
    logic [turfio_pkg::WB_DATA_WIDTH-1:0]             wb_dat_w;
    logic [turfio_pkg::WB_DATA_WIDTH-1:0]             wb_dat_r;
    logic                                             wb_ack;
    logic                                             wb_err;
    logic                                             cmd_pps;
    logic [turfio_pkg::TRIG_TIME_WIDTH-1:0]           trig_time;
    logic                                             trig_valid;
    logic                                             sync;
    logic [turfio_pkg::CLOCK_COUNT_WIDTH-1:0]         sysclk_count;

    always #5 sysclk = ~sysclk;

    pueo_turfio #(
        .IDENT         (IDENT),
        .VER_MAJOR     (VER_MAJOR),
        .VER_MINOR     (VER_MINOR),
        .VER_REV       (VER_REV),
        .FIRMWARE_DATE (FIRMWARE_DATE)
    ) i_pueo_turfio (
        .sysclk_i       (sysclk),
        .rst_n_i        (rst_n),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_dat_o       (wb_dat_r),
        .wb_ack_o       (wb_ack),
        .wb_err_o       (wb_err),
        .cmd_pps_o      (cmd_pps),
        .trig_time_o    (trig_time),
        .trig_valid_o   (trig_valid),
        .sync_o         (sync),
        .sysclk_count_o (sysclk_count)
    );

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input turfio_pkg::cmd_op_e exp,
                            input turfio_pkg::cmd_op_e act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_time(input string name, input logic [14:0] exp, input logic [14:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %04h, actual %04h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [47:0] exp, input logic [47:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %012h, actual %012h", name, exp, act);
            abort_run();
        end
    endtask

    // Status bits (ack, err, sync)
    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // Decoded strobes as an opcode, both high gives an illegal code
    function automatic turfio_pkg::cmd_op_e strobe_op(input logic pps, input logic trig);
        case ({pps, trig})
            2'b00:   return turfio_pkg::CMD_NOP;
            2'b10:   return turfio_pkg::CMD_PPS;
            2'b01:   return turfio_pkg::CMD_TRIG;
            default: return turfio_pkg::cmd_op_e'(4'hf);
        endcase
    endfunction

    // Only TRIG and PPS show on the outputs
    function automatic turfio_pkg::cmd_op_e visible_op(input logic [31:0] word);
        if (word[31:28] == turfio_pkg::CMD_TRIG) return turfio_pkg::CMD_TRIG;
        if (word[31:28] == turfio_pkg::CMD_PPS) return turfio_pkg::CMD_PPS;
        return turfio_pkg::CMD_NOP;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus access, request held until ack or err
    ////////////////////////////////////////////////////////////

    task automatic bus_access(input logic we, input logic [13:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic ack, output logic err);
        int waited;
        waited = 0;
        @(posedge sysclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        @(negedge sysclk);
        while (!wb_ack && !wb_err) begin
            waited++;
            if (waited > BUS_LIMIT) begin
                $display("ERROR: bus access got neither ack nor err");
                abort_run();
            end
            @(negedge sysclk);
        end
        rdata = wb_dat_r;
        ack   = wb_ack;
        err   = wb_err;
        // Drop the request for at least one cycle
        @(posedge sysclk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    function automatic void add_step(input string name, input step_kind_e kind,
                                     input logic [13:0] adr, input logic [31:0] wdata,
                                     input logic [31:0] expected);
        step_t s;
        s.name     = name;
        s.kind     = kind;
        s.adr      = adr;
        s.wdata    = wdata;
        s.expected = expected;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        logic [31:0] rnd;
        logic [31:0] word;
        logic [31:0] ctrl;
        logic [31:0] version;
        logic [14:0] last_trig;
        version = {FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};
        add_step("ident_read", STEP_READ, ADR_IDENT, '0, IDENT);
        add_step("version_read", STEP_READ, ADR_VERSION, '0, version);
        add_step("ctrl_after_reset", STEP_READ, ADR_CTRL, '0, '0);
        ctrl = $urandom();
        add_step("ctrl_write", STEP_WRITE, ADR_CTRL, ctrl, '0);
        add_step("ctrl_readback", STEP_READ, ADR_CTRL, '0, ctrl & CTRL_MASK);
        // Read-only offsets ignore writes
        add_step("ident_write", STEP_WRITE, ADR_IDENT, $urandom(), '0);
        add_step("ident_unchanged", STEP_READ, ADR_IDENT, '0, IDENT);
        add_step("version_write", STEP_WRITE, ADR_VERSION, $urandom(), '0);
        add_step("version_unchanged", STEP_READ, ADR_VERSION, '0, version);
        add_step("ctrl_unchanged", STEP_READ, ADR_CTRL, '0, ctrl & CTRL_MASK);
        // Unmapped regions
        add_step("region2_read", STEP_ERR, 14'h2000, '0, '0);
        add_step("region3_read", STEP_ERR, 14'h3ffc, '0, '0);
        // Commands, trigger time carried from the last TRIG
        rnd       = $urandom();
        word      = {turfio_pkg::CMD_TRIG, rnd[27:0]};
        last_trig = word[14:0];
        add_step("cmd_trig", STEP_CMD, ADR_CMD, word, {visible_op(word), 13'h0, last_trig});
        add_step("cmd_trig_readback", STEP_READ, ADR_CMD, '0, word);
        rnd  = $urandom();
        word = {turfio_pkg::CMD_PPS, rnd[27:0]};
        add_step("cmd_pps", STEP_CMD, ADR_CMD, word, {visible_op(word), 13'h0, last_trig});
        rnd  = $urandom();
        word = {turfio_pkg::CMD_NOP, rnd[27:0]};
        add_step("cmd_nop", STEP_CMD, ADR_CMD, word, {visible_op(word), 13'h0, last_trig});
        rnd  = $urandom();
        word = {4'hb, rnd[27:0]};
        add_step("cmd_unknown", STEP_CMD, ADR_CMD, word, {visible_op(word), 13'h0, last_trig});
        add_step("cmd_unknown_readback", STEP_READ, ADR_CMD, '0, word);
        // Sync with external sync on, then off
        ctrl = $urandom() | 32'h1;
        add_step("ctrl_sync_on", STEP_WRITE, ADR_CTRL, ctrl, '0);
        rnd = $urandom();
        add_step("sync_enabled", STEP_SYNC, ADR_CMD, {turfio_pkg::CMD_SYNC, rnd[27:0]}, ctrl);
        ctrl = $urandom() & ~32'h1;
        add_step("ctrl_sync_off", STEP_WRITE, ADR_CTRL, ctrl, '0);
        rnd = $urandom();
        add_step("sync_disabled", STEP_SYNC, ADR_CMD, {turfio_pkg::CMD_SYNC, rnd[27:0]}, ctrl);
    endfunction

    ////////////////////////////////////////////////////////////
    // Step execution
    ////////////////////////////////////////////////////////////

    task automatic run_step(input step_t s);
        logic [31:0] rdata;
        logic        ack;
        logic        err;
        logic [47:0] base;
        logic [7:0]  clk_off;
        logic [3:0]  sync_off;
        case (s.kind)
            STEP_READ: begin
                bus_access(1'b0, s.adr, '0, rdata, ack, err);
                check_flag({s.name, " ack"}, 1'b1, ack);
                check_word(s.name, s.expected, rdata);
            end
            STEP_WRITE: begin
                bus_access(1'b1, s.adr, s.wdata, rdata, ack, err);
                check_flag({s.name, " ack"}, 1'b1, ack);
            end
            STEP_ERR: begin
                bus_access(1'b0, s.adr, '0, rdata, ack, err);
                check_flag({s.name, " err"}, 1'b1, err);
                check_flag({s.name, " ack"}, 1'b0, ack);
                check_word(s.name, '0, rdata);
            end
            STEP_CMD: begin
                bus_access(1'b1, s.adr, s.wdata, rdata, ack, err);
                // Two edges after the request was seen
                @(negedge sysclk);
                check_op(s.name, turfio_pkg::cmd_op_e'(s.expected[31:28]),
                         strobe_op(cmd_pps, trig_valid));
                check_time({s.name, " time"}, s.expected[14:0], trig_time);
                @(negedge sysclk);
                check_op({s.name, " strobe end"}, turfio_pkg::CMD_NOP,
                         strobe_op(cmd_pps, trig_valid));
            end
            STEP_SYNC: begin
                clk_off  = s.expected[23:16];
                sync_off = s.expected[11:8];
                bus_access(1'b1, s.adr, s.wdata, rdata, ack, err);
                // Sync request is high here, counter reloads on the next edge
                @(negedge sysclk);
                check_op({s.name, " strobes"}, turfio_pkg::CMD_NOP,
                         strobe_op(cmd_pps, trig_valid));
                base = sysclk_count;
                // Two full sync periods after the reload
                for (int k = 0; k < 33; k++) begin
                    @(negedge sysclk);
                    if (s.expected[0]) begin
                        check_count(s.name, {40'h0, clk_off} + 48'(k), sysclk_count);
                        check_flag({s.name, " sync"}, ((32'(sync_off) + k) % 16) == 0, sync);
                    end else begin
                        check_count(s.name, base + 48'(k + 1), sysclk_count);
                    end
                end
            end
            default: begin
                $display("ERROR: step %s has an unknown kind", s.name);
                abort_run();
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hc3c5));
        build_table();
        rst_n    <= 1'b0;
        wb_cyc   <= 1'b0;
        wb_stb   <= 1'b0;
        wb_we    <= 1'b0;
        wb_adr   <= '0;
        wb_dat_w <= '0;
        repeat (2) @(posedge sysclk);
        rst_n <= 1'b1;
        // First cycle out of reset, phase zero
        @(negedge sysclk);
        check_count("reset count", '0, sysclk_count);
        check_flag("reset sync", 1'b1, sync);
        check_flag("reset ack", 1'b0, wb_ack);
        check_flag("reset err", 1'b0, wb_err);
        check_flag("reset pps", 1'b0, cmd_pps);
        check_flag("reset trig", 1'b0, trig_valid);
        @(negedge sysclk);
        check_count("count after reset", 48'd1, sysclk_count);
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("Test completed successfully");
        $finish;
    end

    // Limit from the table length, longest step just under 40 cycles
    initial begin
        #1;
        repeat (steps.size() * 40 + 200) @(posedge sysclk);
        $display("ERROR: simulation timed out before all steps finished");
        abort_run();
    end

endmodule
